/* bench/tb_lane_bus_table.svh */
/*
  Bus cycles of the arbiter testbench, one row per clock cycle.
  Data bytes are repeated eight times to form the 64-bit words.
  Bus data is only compared on rows that expect a bus valid.
*/

`ifndef TB_LANE_BUS_TABLE_SVH
`define TB_LANE_BUS_TABLE_SVH

// src_v  opq_valid, alu_red_req, fpu_red_req, sldu_red_valid
// rdy    sldu, addrgen, alu_red, fpu_red readies
// ctl    opq_cmd_pop, alu_red_complete, fpu_red_complete, flush
// exp_v  sldu_operand, addrgen_operand, alu_red, fpu_red valids
// exp_r  opq_ready, alu_red_gnt, fpu_red_gnt, sldu_red_gnt
typedef struct packed {
  logic       op_valid;
  ara_op_e    op;
  logic [3:0] src_v;
  logic [3:0] rdy;
  logic [3:0] ctl;
  logic [7:0] opq_d;
  logic [7:0] alu_d;
  logic [7:0] fpu_d;
  logic [3:0] exp_v;
  logic [3:0] exp_r;
  logic [7:0] exp_d;
} row_t;

localparam int NUM_ROWS = 25;

localparam row_t ROWS [NUM_ROWS] = '{
  // Slide, then pop
  '{1'b1, VSLIDEUP,   4'hf, 4'hf, 4'h0, 8'h11, 8'h22, 8'h33, 4'h0, 4'h0, 8'h00},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h0, 8'h11, 8'h22, 8'h33, 4'h0, 4'h0, 8'h00},
  '{1'b0, VADD,       4'hf, 4'h8, 4'h0, 8'h44, 8'h55, 8'h66, 4'h8, 4'h8, 8'h44},
  '{1'b0, VADD,       4'hf, 4'h7, 4'h0, 8'h44, 8'h55, 8'h66, 4'h8, 4'h0, 8'h44},
  '{1'b0, VADD,       4'hf, 4'h8, 4'h8, 8'h44, 8'h55, 8'h66, 4'h8, 4'h8, 8'h44},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h0, 8'h44, 8'h55, 8'h66, 4'h0, 4'h0, 8'h00},
  // Indexed load toward the address generator
  '{1'b1, VLXE,       4'h0, 4'h0, 4'h0, 8'h77, 8'h88, 8'h99, 4'h0, 4'h0, 8'h00},
  '{1'b0, VADD,       4'h0, 4'h0, 4'h0, 8'h77, 8'h88, 8'h99, 4'h0, 4'h0, 8'h00},
  '{1'b0, VADD,       4'hf, 4'h4, 4'h0, 8'h77, 8'h88, 8'h99, 4'h4, 4'h8, 8'h77},
  '{1'b0, VADD,       4'hf, 4'hb, 4'h8, 8'h77, 8'h88, 8'h99, 4'h4, 4'h0, 8'h77},
  // ALU reduction, FP reduction, slide, in that order
  '{1'b1, VREDSUM,    4'hf, 4'hf, 4'h0, 8'ha1, 8'hb2, 8'hc3, 4'h0, 4'h0, 8'h00},
  '{1'b1, VFREDUSUM,  4'hf, 4'hf, 4'h0, 8'ha1, 8'hb2, 8'hc3, 4'h0, 4'h0, 8'h00},
  '{1'b1, VSLIDEDOWN, 4'hf, 4'hf, 4'h0, 8'ha1, 8'hb2, 8'hc3, 4'ha, 4'h5, 8'hb2},
  '{1'b0, VADD,       4'hf, 4'h5, 4'ha, 8'ha1, 8'hb2, 8'hc3, 4'ha, 4'h0, 8'hb2},
  '{1'b0, VADD,       4'h5, 4'ha, 4'h4, 8'ha1, 8'hb2, 8'hc3, 4'ha, 4'h5, 8'hb2},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h0, 8'hd4, 8'he5, 8'hf6, 4'h9, 4'h3, 8'hf6},
  '{1'b0, VADD,       4'hf, 4'he, 4'h4, 8'hd4, 8'he5, 8'hf6, 4'h9, 4'h2, 8'hf6},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h2, 8'hd4, 8'he5, 8'hf6, 4'h9, 4'h3, 8'hf6},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h8, 8'h5a, 8'h6b, 8'h7c, 4'h8, 4'h8, 8'h5a},
  // Non-bus operation, then flush with two entries pending
  '{1'b1, VADD,       4'hf, 4'hf, 4'h0, 8'h5a, 8'h6b, 8'h7c, 4'h0, 4'h0, 8'h00},
  '{1'b1, VSLIDEUP,   4'hf, 4'hf, 4'h0, 8'h5a, 8'h6b, 8'h7c, 4'h0, 4'h0, 8'h00},
  '{1'b1, VREDSUM,    4'hf, 4'hf, 4'h0, 8'h5a, 8'h6b, 8'h7c, 4'h0, 4'h0, 8'h00},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h1, 8'h8c, 8'h9d, 8'hae, 4'h8, 4'h8, 8'h8c},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h0, 8'h8c, 8'h9d, 8'hae, 4'h8, 4'h8, 8'h8c},
  '{1'b0, VADD,       4'hf, 4'hf, 4'h0, 8'h8c, 8'h9d, 8'hae, 4'h0, 4'h0, 8'h00}
};

`endif

/* bench/tb_lane_bus.sv */
/*
  Testbench of the lane's shared operand bus arbiter.
  Runs the cycle table first, then a random mask stream under random
  back-pressure, checked against a scoreboard queue.
*/

module tb_lane_bus;
  import lane_bus_pkg::*;

  `include "tb_lane_bus_table.svh"

  localparam int MASK_WORDS  = 40;
  localparam int CYCLE_LIMIT = NUM_ROWS + MASK_WORDS + 50;

  logic    clk_i, rst_i, op_valid_i, flush_i;
  ara_op_e op_i;
  elen_t   opq_operand_i, alu_red_operand_i, fpu_red_operand_i, sldu_addrgen_operand_o;
  logic    opq_valid_i, opq_ready_o, opq_cmd_pop_i;
  logic    alu_red_req_i, alu_red_gnt_o, alu_red_complete_i;
  logic    fpu_red_req_i, fpu_red_gnt_o, fpu_red_complete_i;
  logic    sldu_operand_valid_o, addrgen_operand_valid_o;
  logic    sldu_operand_ready_i, addrgen_operand_ready_i;
  logic    sldu_red_valid_i, sldu_red_gnt_o, alu_red_valid_o, alu_red_ready_i;
  logic    fpu_red_valid_o, fpu_red_ready_i;
  strb_t   mask_i, mask_o, exp_mask;
  logic    mask_valid_i, mask_ready_o, mask_valid_o, mask_ready_i;

  integer  seed = 93235;
  integer  rnd, table_errs, mask_errs, cycles, sent, recvd;
  logic    taken;
  strb_t   sb_q [$];
  row_t    idle_r;

  // Bit 0 first, matching exp_v and exp_r of the table
  string valid_names [4] = '{"fpu_red_valid_o", "alu_red_valid_o",
                             "addrgen_operand_valid_o", "sldu_operand_valid_o"};
  string ready_names [4] = '{"sldu_red_gnt_o", "fpu_red_gnt_o",
                             "alu_red_gnt_o", "opq_ready_o"};

  lane_bus dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic apply_row(input row_t r);
    op_valid_i = r.op_valid;
    op_i       = r.op;
    {opq_valid_i, alu_red_req_i, fpu_red_req_i, sldu_red_valid_i} = r.src_v;
    {sldu_operand_ready_i, addrgen_operand_ready_i} = r.rdy[3:2];
    {alu_red_ready_i, fpu_red_ready_i} = r.rdy[1:0];
    {opq_cmd_pop_i, alu_red_complete_i, fpu_red_complete_i, flush_i} = r.ctl;
    opq_operand_i     = {8{r.opq_d}};
    alu_red_operand_i = {8{r.alu_d}};
    fpu_red_operand_i = {8{r.fpu_d}};
  endtask

  task automatic check_row(input string tag, input row_t r);
    logic [3:0] act_v;
    logic [3:0] act_r;
    elen_t      exp_d;
    int         b;
    act_v = {sldu_operand_valid_o, addrgen_operand_valid_o,
             alu_red_valid_o, fpu_red_valid_o};
    act_r = {opq_ready_o, alu_red_gnt_o, fpu_red_gnt_o, sldu_red_gnt_o};
    exp_d = {8{r.exp_d}};
    for (b = 0; b < 4; b++) begin
      if (act_v[b] !== r.exp_v[b]) begin
        $display("ERR %s expected %h got %h at %s", valid_names[b], r.exp_v[b], act_v[b], tag);
        table_errs++;
      end
      if (act_r[b] !== r.exp_r[b]) begin
        $display("ERR %s expected %h got %h at %s", ready_names[b], r.exp_r[b], act_r[b], tag);
        table_errs++;
      end
    end
    // Data only matters while the bus carries a valid
    if ((r.exp_v[3] || r.exp_v[2]) && sldu_addrgen_operand_o !== exp_d) begin
      $display("ERR sldu_addrgen_operand_o expected %h got %h at %s",
               exp_d, sldu_addrgen_operand_o, tag);
      table_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    table_errs   = 0;
    mask_errs    = 0;
    rst_i        = 1'b1;
    mask_i       = '0;
    mask_valid_i = 1'b0;
    mask_ready_i = 1'b0;
    apply_row('0);
    repeat (4) @(posedge clk_i);
    #10 rst_i = 1'b0;
    // All sources and readies high, only an empty FIFO keeps the bus quiet
    idle_r       = '0;
    idle_r.src_v = 4'hf;
    idle_r.rdy   = 4'hf;
    apply_row(idle_r);
    #80 check_row("reset", idle_r);
    if (mask_ready_o !== 1'b1) begin
      $display("ERR mask_ready_o expected 1 got %h after reset", mask_ready_o);
      table_errs++;
    end
    if (mask_valid_o !== 1'b0) begin
      $display("ERR mask_valid_o expected 0 got %h after reset", mask_valid_o);
      table_errs++;
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk_i);
      #10 apply_row(ROWS[i]);
      #80 check_row($sformatf("row %0d", i), ROWS[i]);
    end

    // Mask stream, valid held until taken, random sink ready
    sent  = 0;
    recvd = 0;
    taken = 1'b1;
    while (recvd < MASK_WORDS) begin
      @(posedge clk_i);
      #10;
      if (sent < MASK_WORDS) begin
        if (taken) begin
          rnd    = $random(seed);
          mask_i = strb_t'(rnd);
        end
        mask_valid_i = 1'b1;
      end else begin
        mask_valid_i = 1'b0;
      end
      rnd          = $random(seed);
      mask_ready_i = (rnd[1:0] != 2'b00);
      #80;
      taken = mask_valid_i && mask_ready_o;
      if (taken) begin
        sb_q.push_back(mask_i);
        sent++;
      end
      if (mask_valid_o && mask_ready_i) begin
        if (sb_q.size() == 0) begin
          $display("Mask word %h came out while no word was outstanding", mask_o);
          mask_errs++;
        end else begin
          exp_mask = sb_q.pop_front();
          if (mask_o !== exp_mask) begin
            $display("ERR mask_o expected %h got %h", exp_mask, mask_o);
            mask_errs++;
          end
        end
        recvd++;
      end
    end

    // Nothing may follow the last word
    repeat (3) begin
      @(posedge clk_i);
      #10 mask_ready_i = 1'b1;
      #80;
      if (mask_valid_o) begin
        $display("Extra mask word %h appeared after the last one", mask_o);
        mask_errs++;
      end
    end

    $display("Errors: %0d table, %0d mask", table_errs, mask_errs);
    if (table_errs + mask_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Timeout

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Errors: %0d table, %0d mask", table_errs, mask_errs);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+src
+incdir+bench
src/lane_bus_pkg.sv
src/sel_fifo.sv
src/order_tracker.sv
src/bus_steer.sv
src/mask_spill.sv
src/lane_bus.sv
bench/tb_lane_bus.sv

/* src/bus_steer.sv */
/*
  Steering of the shared operand bus by the class at the FIFO head.
  Purely combinational. With an empty FIFO no source owns the bus,
  so every valid, ready and gnt output is low.
*/

module bus_steer (
  input  lane_bus_pkg::bus_sel_e head_sel_i,
  input  logic                   empty_i,
  // Operand queue stream
  input  lane_bus_pkg::elen_t    opq_operand_i,
  input  logic                   opq_valid_i,
  output logic                   opq_ready_o,
  // ALU reduction stream
  input  lane_bus_pkg::elen_t    alu_red_operand_i,
  input  logic                   alu_red_req_i,
  output logic                   alu_red_gnt_o,
  // FPU reduction stream
  input  lane_bus_pkg::elen_t    fpu_red_operand_i,
  input  logic                   fpu_red_req_i,
  output logic                   fpu_red_gnt_o,
  // Shared bus toward slide unit and address generator
  output lane_bus_pkg::elen_t    sldu_addrgen_operand_o,
  output logic                   sldu_operand_valid_o,
  output logic                   addrgen_operand_valid_o,
  input  logic                   sldu_operand_ready_i,
  input  logic                   addrgen_operand_ready_i,
  // Reduction return path
  input  logic                   sldu_red_valid_i,
  output logic                   sldu_red_gnt_o,
  output logic                   alu_red_valid_o,
  input  logic                   alu_red_ready_i,
  output logic                   fpu_red_valid_o,
  input  logic                   fpu_red_ready_i
);
  import lane_bus_pkg::*;

  logic sldu_sel, addr_sel, alu_sel, fpu_sel;

  assign sldu_sel = !empty_i && (head_sel_i == SLDU_SEL);
  assign addr_sel = !empty_i && (head_sel_i == ADDRGEN_SEL);
  assign alu_sel  = !empty_i && (head_sel_i == ALU_RED_SEL);
  assign fpu_sel  = !empty_i && (head_sel_i == FPU_RED_SEL);

  // Data goes to both units, only the valid is split
  assign sldu_addrgen_operand_o = alu_sel ? alu_red_operand_i :
                                  fpu_sel ? fpu_red_operand_i : opq_operand_i;

  assign sldu_operand_valid_o = (sldu_sel && opq_valid_i) ||
                                (alu_sel && alu_red_req_i) ||
                                (fpu_sel && fpu_red_req_i);
  assign addrgen_operand_valid_o = addr_sel && opq_valid_i;

  // Ready comes back from whichever unit was chosen
  assign opq_ready_o   = (sldu_sel && sldu_operand_ready_i) ||
                         (addr_sel && addrgen_operand_ready_i);
  assign alu_red_gnt_o = alu_sel && sldu_operand_ready_i;
  assign fpu_red_gnt_o = fpu_sel && sldu_operand_ready_i;

  // Slide unit results go back to the reducing unit
  assign alu_red_valid_o = alu_sel && sldu_red_valid_i;
  assign fpu_red_valid_o = fpu_sel && sldu_red_valid_i;
  assign sldu_red_gnt_o  = (alu_sel && alu_red_ready_i) ||
                           (fpu_sel && fpu_red_ready_i);

endmodule

/* src/lane_bus.sv */
/*
  Arbiter of the lane's shared operand bus, in instruction order.
  An operation reaches the order FIFO two edges after op_valid_i.
  flush_i takes effect one cycle late, through its own register.
  At most NR_VINSN bus operations may be outstanding.
*/

`include "lane_bus_defs.svh"

module lane_bus (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Incoming operations
  input  logic                   op_valid_i,
  input  lane_bus_pkg::ara_op_e  op_i,
  input  logic                   flush_i,
  // Operand queue stream
  input  lane_bus_pkg::elen_t    opq_operand_i,
  input  logic                   opq_valid_i,
  output logic                   opq_ready_o,
  input  logic                   opq_cmd_pop_i,
  // Reduction streams
  input  lane_bus_pkg::elen_t    alu_red_operand_i,
  input  logic                   alu_red_req_i,
  output logic                   alu_red_gnt_o,
  input  logic                   alu_red_complete_i,
  input  lane_bus_pkg::elen_t    fpu_red_operand_i,
  input  logic                   fpu_red_req_i,
  output logic                   fpu_red_gnt_o,
  input  logic                   fpu_red_complete_i,
  // Shared bus
  output lane_bus_pkg::elen_t    sldu_addrgen_operand_o,
  output logic                   sldu_operand_valid_o,
  output logic                   addrgen_operand_valid_o,
  input  logic                   sldu_operand_ready_i,
  input  logic                   addrgen_operand_ready_i,
  // Reduction return path
  input  logic                   sldu_red_valid_i,
  output logic                   sldu_red_gnt_o,
  output logic                   alu_red_valid_o,
  input  logic                   alu_red_ready_i,
  output logic                   fpu_red_valid_o,
  input  logic                   fpu_red_ready_i,
  // Mask stream
  input  lane_bus_pkg::strb_t    mask_i,
  input  logic                   mask_valid_i,
  output logic                   mask_ready_o,
  output lane_bus_pkg::strb_t    mask_o,
  output logic                   mask_valid_o,
  input  logic                   mask_ready_i
);
  import lane_bus_pkg::*;

  logic     flush_q;
  logic     push, pop, empty;
  bus_sel_e push_sel, head_sel;

  always_ff @(posedge clk_i) begin
    if (rst_i) flush_q <= 1'b0;
    else       flush_q <= flush_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Order tracking

  order_tracker u_tracker (
    .clk_i, .rst_i, .op_valid_i, .op_i,
    .head_sel_i (head_sel), .empty_i (empty),
    .opq_cmd_pop_i, .alu_red_complete_i, .fpu_red_complete_i,
    .push_o (push), .push_sel_o (push_sel), .pop_o (pop)
  );

  sel_fifo #(.DEPTH(`NR_VINSN)) u_fifo (
    .clk_i, .rst_i, .flush_i (flush_q),
    .push_i (push), .data_i (push_sel), .pop_i (pop),
    .data_o (head_sel), .empty_o (empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bus steering and mask spill

  bus_steer u_steer (
    .head_sel_i (head_sel), .empty_i (empty),
    .opq_operand_i, .opq_valid_i, .opq_ready_o,
    .alu_red_operand_i, .alu_red_req_i, .alu_red_gnt_o,
    .fpu_red_operand_i, .fpu_red_req_i, .fpu_red_gnt_o,
    .sldu_addrgen_operand_o, .sldu_operand_valid_o, .addrgen_operand_valid_o,
    .sldu_operand_ready_i, .addrgen_operand_ready_i,
    .sldu_red_valid_i, .sldu_red_gnt_o,
    .alu_red_valid_o, .alu_red_ready_i, .fpu_red_valid_o, .fpu_red_ready_i
  );

  mask_spill u_mask_spill (
    .clk_i, .rst_i, .mask_i, .mask_valid_i, .mask_ready_o,
    .mask_o, .mask_valid_o, .mask_ready_i
  );

endmodule

/* src/lane_bus_defs.svh */
/*
  Sizes of the shared operand bus arbiter.
  STRB_W must stay ELEN/8, one mask bit per byte of a bus word.
  NR_VINSN bounds the number of outstanding bus operations and
  is the default depth of the order FIFO.
*/

`ifndef LANE_BUS_DEFS_SVH
`define LANE_BUS_DEFS_SVH

// Bus data width in bits
`define ELEN 64

// Mask word, one bit per byte
`define STRB_W (`ELEN / 8)

// Outstanding operations
`define NR_VINSN 8

// Operation code width
`define OP_W 5

`endif

/* src/lane_bus_pkg.sv */
/*
  Types shared by the operand bus arbiter.
  The reduction ranges of ara_op_e must stay contiguous, because the
  classifier works with range tests on them.
*/

`include "lane_bus_defs.svh"

package lane_bus_pkg;

  typedef logic [`ELEN-1:0]   elen_t;
  typedef logic [`STRB_W-1:0] strb_t;

  typedef enum logic [`OP_W-1:0] {
    VADD,
    VSLIDEUP, VSLIDEDOWN,
    VLXE, VSXE,
    // ALU reductions, VREDSUM first and VWREDSUM last
    VREDSUM, VREDAND, VREDOR, VREDXOR,
    VREDMINU, VREDMIN, VREDMAXU, VREDMAX,
    VWREDSUMU, VWREDSUM,
    // FP reductions, VFREDUSUM first and VFWREDOSUM last
    VFREDUSUM, VFREDOSUM, VFREDMIN, VFREDMAX,
    VFWREDUSUM, VFWREDOSUM
  } ara_op_e;

  // Owner of the shared bus
  typedef enum logic [1:0] {
    SLDU_SEL    = 2'd0,
    ADDRGEN_SEL = 2'd1,
    ALU_RED_SEL = 2'd2,
    FPU_RED_SEL = 2'd3
  } bus_sel_e;

endpackage

/* src/mask_spill.sv */
/*
  Two-slot spill register on the mask stream.
  mask_ready_o comes from a flop, never from mask_ready_i in the same
  cycle. Words leave one or more cycles after they enter, in order.
*/

module mask_spill (
  input  logic                clk_i,
  input  logic                rst_i,
  input  lane_bus_pkg::strb_t mask_i,
  input  logic                mask_valid_i,
  output logic                mask_ready_o,
  output lane_bus_pkg::strb_t mask_o,
  output logic                mask_valid_o,
  input  logic                mask_ready_i
);
  import lane_bus_pkg::*;

  strb_t a_data_q, b_data_q;
  logic  a_full_q, b_full_q;
  logic  a_fill, a_drain, b_fill, b_drain;

  // A takes new words, B catches what A held when the sink stalls
  assign a_fill  = mask_valid_i && mask_ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !mask_ready_i;
  assign b_drain = b_full_q && mask_ready_i;

  // While B is empty, A always frees up this cycle
  assign mask_ready_o = !b_full_q;
  assign mask_valid_o = a_full_q || b_full_q;
  assign mask_o       = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= mask_i;
    if (b_fill) b_data_q <= a_data_q;
  end

endmodule

/* src/order_tracker.sv */
/*
  Keeps the order FIFO in instruction order.
  The operation strobe is registered once, so a class is pushed one
  cycle after the operation is accepted. VADD and other non-bus
  operations push nothing. A completion pulse only pops when it
  belongs to the class at the head; other pulses are ignored.
*/

module order_tracker (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   op_valid_i,
  input  lane_bus_pkg::ara_op_e  op_i,
  input  lane_bus_pkg::bus_sel_e head_sel_i,
  input  logic                   empty_i,
  input  logic                   opq_cmd_pop_i,
  input  logic                   alu_red_complete_i,
  input  logic                   fpu_red_complete_i,
  output logic                   push_o,
  output lane_bus_pkg::bus_sel_e push_sel_o,
  output logic                   pop_o
);
  import lane_bus_pkg::*;

  logic    op_valid_q;
  ara_op_e op_q;

  ////////////////////////////////////////////////////////////////////////////
  // Input register

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i) op_q <= op_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Classification and completion

  always_comb begin
    push_o     = 1'b0;
    push_sel_o = SLDU_SEL;
    if (op_valid_q) begin
      case (op_q) inside
        VSLIDEUP, VSLIDEDOWN: begin
          push_o     = 1'b1;
          push_sel_o = SLDU_SEL;
        end
        VLXE, VSXE: begin
          push_o     = 1'b1;
          push_sel_o = ADDRGEN_SEL;
        end
        [VREDSUM:VWREDSUM]: begin
          push_o     = 1'b1;
          push_sel_o = ALU_RED_SEL;
        end
        [VFREDUSUM:VFWREDOSUM]: begin
          push_o     = 1'b1;
          push_sel_o = FPU_RED_SEL;
        end
        default: push_o = 1'b0;
      endcase
    end
  end

  // Slides and indexed accesses both end on the operand queue pop
  always_comb begin
    pop_o = 1'b0;
    if (!empty_i) begin
      case (head_sel_i)
        SLDU_SEL, ADDRGEN_SEL: pop_o = opq_cmd_pop_i;
        ALU_RED_SEL:           pop_o = alu_red_complete_i;
        FPU_RED_SEL:           pop_o = fpu_red_complete_i;
        default:               pop_o = 1'b0;
      endcase
    end
  end

endmodule

/* src/sel_fifo.sv */
/*
  Order FIFO of source classes.
  A push while full is dropped and a pop while empty is ignored.
  data_o is only meaningful while empty_o is low.
  flush_i clears the pointers at the next edge and wins over a push.
*/

`include "lane_bus_defs.svh"

module sel_fifo #(
  parameter int unsigned DEPTH = `NR_VINSN
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  lane_bus_pkg::bus_sel_e data_i,
  input  logic                  pop_i,
  output lane_bus_pkg::bus_sel_e data_o,
  output logic                  empty_o
);
  import lane_bus_pkg::*;

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  bus_sel_e      mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AW:0]   count_q;
  logic          full, do_push, do_pop;

  // Wrap explicitly so that odd depths behave too
  function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] ptr);
    next_ptr = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == (AW+1)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule
